/* source/cmd_link_consts.svh */
`ifndef CMD_LINK_CONSTS_SVH
`define CMD_LINK_CONSTS_SVH

// Command RAM address width, 256 bytes of storage
`define CMD_ADDR_W 8

// First byte of the frame in the command RAM
`define CMD_BASE_ADDR 8'h0A

// Key pair twice, func, rate, filters, triggers, delays and checksum
`define CMD_FRAME_LEN 18

// Only frames carrying this key in both copies are accepted
`define CMD_KEY 16'h55AA

`endif

/* source/cmd_frame_pkg.sv */
package cmd_frame_pkg;

    // Opcodes travel as a byte with the upper nibble cleared
    typedef enum logic [3:0] {
        FUNC_START  = 4'h1,
        FUNC_CONFIG = 4'h2,
        FUNC_STOP   = 4'h3
    } cmd_func_e;

    // Host request, one frame worth of fields
    typedef struct packed {
        logic [15:0] key;
        logic [7:0]  func;
        logic [7:0]  rate;
        logic [7:0]  lfilt;
        logic [7:0]  hfilt;
        logic [7:0]  trig0;
        logic [7:0]  trig1;
        logic [15:0] dly0;
        logic [15:0] dly1;
    } cmd_req_t;

    // Write port of the command RAM
    typedef struct packed {
        logic       we;
        logic [7:0] addr;
        logic [7:0] data;
    } ram_wr_t;

    typedef enum logic [1:0] {
        IDLE,
        WRITE,
        WAIT_DONE
    } wr_state_e;

endpackage

/* source/cmd_decode_pkg.sv */
package cmd_decode_pkg;

    // Frame verdict, driven out on btype
    typedef enum logic [3:0] {
        ST_NONE     = 4'h0,
        ST_OK       = 4'h1,
        ST_BAD_KEY  = 4'h2,
        ST_BAD_SUM  = 4'h3,
        ST_BAD_FUNC = 4'h4
    } cmd_status_e;

    // Last accepted command, key and checksum already stripped
    typedef struct packed {
        cmd_frame_pkg::cmd_func_e func;
        logic [7:0]               rate;
        logic [7:0]               lfilt;
        logic [7:0]               hfilt;
        logic [7:0]               trig0;
        logic [7:0]               trig1;
        logic [15:0]              dly0;
        logic [15:0]              dly1;
    } cmd_decode_t;

    typedef enum logic [1:0] {
        IDLE,
        FETCH,
        CHECK,
        DONE
    } rd_state_e;

endpackage

/* source/cmd_frame_writer.sv */
`timescale 1ns/1ps
`include "cmd_link_consts.svh"

module cmd_frame_writer (
    input  logic                   clk,
    input  logic                   rst,
    input  cmd_frame_pkg::cmd_req_t req,
    input  logic                   send,
    input  logic                   fd,
    output logic                   busy,
    output cmd_frame_pkg::ram_wr_t  wr,
    output logic                   fs
);

    localparam logic [4:0] LAST_BYTE = 5'(`CMD_FRAME_LEN - 1);

    cmd_frame_pkg::wr_state_e state;
    cmd_frame_pkg::cmd_req_t  req_q;   // Held until the frame is fully written
    logic [4:0]               cnt;
    logic [15:0]              csum;
    logic [7:0]               byte_out;

    // Wrapping sum over the same terms the reader accumulates
    assign csum = req_q.key + {8'h00, req_q.func} + {8'h00, req_q.rate}
                + {req_q.lfilt, req_q.hfilt} + {req_q.trig0, req_q.trig1}
                + req_q.dly0 + req_q.dly1;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= cmd_frame_pkg::IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                cmd_frame_pkg::IDLE: begin
                    if (send) begin   // Sends arriving in any other state are dropped
                        state <= cmd_frame_pkg::WRITE;
                        cnt   <= '0;
                    end
                end
                cmd_frame_pkg::WRITE: begin
                    if (cnt == LAST_BYTE) begin
                        state <= cmd_frame_pkg::WAIT_DONE;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                cmd_frame_pkg::WAIT_DONE: begin
                    if (fd) state <= cmd_frame_pkg::IDLE;
                end
                default: state <= cmd_frame_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cmd_frame_pkg::IDLE && send) req_q <= req;
    end

    // Frame layout, one byte per offset from the base address
    always_comb begin
        case (cnt)
            5'd0, 5'd2: byte_out = req_q.key[15:8];
            5'd1, 5'd3: byte_out = req_q.key[7:0];
            5'd5:       byte_out = req_q.func;
            5'd7:       byte_out = req_q.rate;
            5'd8:       byte_out = req_q.lfilt;
            5'd9:       byte_out = req_q.hfilt;
            5'd10:      byte_out = req_q.trig0;
            5'd11:      byte_out = req_q.trig1;
            5'd12:      byte_out = req_q.dly0[15:8];
            5'd13:      byte_out = req_q.dly0[7:0];
            5'd14:      byte_out = req_q.dly1[15:8];
            5'd15:      byte_out = req_q.dly1[7:0];
            5'd16:      byte_out = csum[15:8];
            5'd17:      byte_out = csum[7:0];
            default:    byte_out = 8'h00;   // Reserved bytes at offsets 4 and 6
        endcase
    end

    assign wr = '{
        we:   (state == cmd_frame_pkg::WRITE),
        addr: `CMD_BASE_ADDR + {{(`CMD_ADDR_W - 5){1'b0}}, cnt},
        data: byte_out
    };

    assign busy = (state != cmd_frame_pkg::IDLE);
    assign fs   = (state == cmd_frame_pkg::WAIT_DONE);   // Held until the reader answers

endmodule

/* source/cmd_frame_ram.sv */
`timescale 1ns/1ps
`include "cmd_link_consts.svh"

module cmd_frame_ram (
    input  logic                    clk,
    input  cmd_frame_pkg::ram_wr_t   wr,
    input  logic [`CMD_ADDR_W-1:0]  rd_addr,
    output logic [7:0]              rd_data
);

    localparam int DEPTH = 2 ** `CMD_ADDR_W;

    logic [7:0] mem [DEPTH];

    always_ff @(posedge clk) begin
        if (wr.we) mem[wr.addr] <= wr.data;
    end

    // Read is registered, data follows the address by one cycle
    always_ff @(posedge clk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

/* source/cmd_frame_reader.sv */
`timescale 1ns/1ps
`include "cmd_link_consts.svh"

module cmd_frame_reader (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        fs,
    input  logic [7:0]                  rd_data,
    output logic [`CMD_ADDR_W-1:0]      rd_addr,
    output logic                        fd,
    output cmd_decode_pkg::cmd_status_e status,
    output cmd_decode_pkg::cmd_decode_t cmd
);

    // Counter value in the cycle the last frame byte comes back
    localparam logic [4:0] LAST_CNT = 5'(`CMD_FRAME_LEN);

    cmd_decode_pkg::rd_state_e   state;
    cmd_decode_pkg::cmd_status_e verdict;
    cmd_frame_pkg::cmd_req_t     rec;   // Working copy of the frame being fetched
    logic                        fs_q;
    logic [4:0]                  cnt;
    logic [4:0]                  idx;
    logic [15:0]                 key_copy;
    logic [15:0]                 sum_rx;
    logic [15:0]                 sum_acc;
    logic                        func_ok;

    // Address 0 is already presented while idle, so the fetch starts at once
    assign rd_addr = `CMD_BASE_ADDR + {{(`CMD_ADDR_W - 5){1'b0}}, cnt};
    assign idx     = cnt - 5'd1;   // Offset of the byte now on rd_data
    assign fd      = (state == cmd_decode_pkg::DONE);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state  <= cmd_decode_pkg::IDLE;
            fs_q   <= 1'b0;
            cnt    <= '0;
            status <= cmd_decode_pkg::ST_NONE;
            cmd    <= '0;
        end else begin
            fs_q <= fs;
            case (state)
                cmd_decode_pkg::IDLE: begin
                    if (fs && !fs_q) begin
                        state <= cmd_decode_pkg::FETCH;
                        cnt   <= 5'd1;
                    end
                end
                cmd_decode_pkg::FETCH: begin
                    if (cnt == LAST_CNT) begin
                        state <= cmd_decode_pkg::CHECK;
                        cnt   <= '0;
                    end else begin
                        cnt <= cnt + 5'd1;
                    end
                end
                cmd_decode_pkg::CHECK: begin
                    state  <= cmd_decode_pkg::DONE;
                    status <= verdict;
                    if (verdict == cmd_decode_pkg::ST_OK) begin   // Rejected frames leave cmd alone
                        cmd <= '{
                            func:  cmd_frame_pkg::cmd_func_e'(rec.func[3:0]),
                            rate:  rec.rate,
                            lfilt: rec.lfilt,
                            hfilt: rec.hfilt,
                            trig0: rec.trig0,
                            trig1: rec.trig1,
                            dly0:  rec.dly0,
                            dly1:  rec.dly1
                        };
                    end
                end
                default: state <= cmd_decode_pkg::IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == cmd_decode_pkg::FETCH) begin
            case (idx)
                5'd0:    rec.key[15:8]   <= rd_data;
                5'd1:    rec.key[7:0]    <= rd_data;
                5'd2:    key_copy[15:8]  <= rd_data;
                5'd3:    key_copy[7:0]   <= rd_data;
                5'd5:    rec.func        <= rd_data;
                5'd7:    rec.rate        <= rd_data;
                5'd8:    rec.lfilt       <= rd_data;
                5'd9:    rec.hfilt       <= rd_data;
                5'd10:   rec.trig0       <= rd_data;
                5'd11:   rec.trig1       <= rd_data;
                5'd12:   rec.dly0[15:8]  <= rd_data;
                5'd13:   rec.dly0[7:0]   <= rd_data;
                5'd14:   rec.dly1[15:8]  <= rd_data;
                5'd15:   rec.dly1[7:0]   <= rd_data;
                5'd16:   sum_rx[15:8]    <= rd_data;
                5'd17:   sum_rx[7:0]     <= rd_data;
                default: ;
            endcase
        end
    end

    // Running checksum, high bytes of each word land in the upper half
    always_ff @(posedge clk) begin
        if (state == cmd_decode_pkg::IDLE) begin
            sum_acc <= '0;
        end else if (state == cmd_decode_pkg::FETCH) begin
            if (idx inside {5'd0, 5'd8, 5'd10, 5'd12, 5'd14})
                sum_acc <= sum_acc + {rd_data, 8'h00};
            else if (idx inside {5'd1, 5'd5, 5'd7, 5'd9, 5'd11, 5'd13, 5'd15})
                sum_acc <= sum_acc + {8'h00, rd_data};
        end
    end

    always_comb begin
        func_ok = (rec.func[7:4] == 4'h0) && (rec.func[3:0] inside {
            cmd_frame_pkg::FUNC_START, cmd_frame_pkg::FUNC_CONFIG, cmd_frame_pkg::FUNC_STOP});
        // Key first, then checksum, then opcode
        if (rec.key != `CMD_KEY || key_copy != `CMD_KEY)
            verdict = cmd_decode_pkg::ST_BAD_KEY;
        else if (sum_acc != sum_rx)
            verdict = cmd_decode_pkg::ST_BAD_SUM;
        else if (!func_ok)
            verdict = cmd_decode_pkg::ST_BAD_FUNC;
        else
            verdict = cmd_decode_pkg::ST_OK;
    end

endmodule

/* source/cmd_link_top.sv */
`timescale 1ns/1ps
`include "cmd_link_consts.svh"

module cmd_link_top (
    input  logic                        clk,
    input  logic                        rst,
    input  cmd_frame_pkg::cmd_req_t     req,
    input  logic                        send,
    output logic                        busy,
    output logic                        done,
    output cmd_decode_pkg::cmd_status_e status,
    output cmd_decode_pkg::cmd_decode_t cmd
);

    cmd_frame_pkg::ram_wr_t       wr;
    logic [`CMD_ADDR_W-1:0]      rd_addr;
    logic [7:0]                  rd_data;
    logic                        fs;
    logic                        fd;

    cmd_frame_writer i_writer (
        .clk  (clk),
        .rst  (rst),
        .req  (req),
        .send (send),
        .fd   (fd),
        .busy (busy),
        .wr   (wr),
        .fs   (fs)
    );

    cmd_frame_ram i_ram (
        .clk     (clk),
        .wr      (wr),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    cmd_frame_reader i_reader (
        .clk     (clk),
        .rst     (rst),
        .fs      (fs),
        .rd_data (rd_data),
        .rd_addr (rd_addr),
        .fd      (fd),
        .status  (status),
        .cmd     (cmd)
    );

    assign done = fd;   // The reader's answer doubles as the host done pulse

endmodule

/* bench/cmd_link_props.sv */
`timescale 1ns/1ps

module cmd_link_props (
    input logic                        clk,
    input logic                        rst,
    input logic                        fs,
    input logic                        fd,
    input cmd_decode_pkg::cmd_status_e status
);

    logic seen_fd;   // Set once the first frame has been answered

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            seen_fd <= 1'b0;
        end else if (fd) begin
            seen_fd <= 1'b1;
        end
    end

    fd_single_pulse: assert property (@(posedge clk) disable iff (rst) fd |=> !fd)
        else $error("fd stayed high for more than one cycle");

    fd_within_fs: assert property (@(posedge clk) disable iff (rst) fd |-> fs)
        else $error("fd pulsed while fs was low");

    // The first verdict shows up together with the first fd
    status_idle_until_fd: assert property (@(posedge clk) disable iff (rst)
        (status != cmd_decode_pkg::ST_NONE) |-> (seen_fd || fd))
        else $error("status left ST_NONE before any fd");

endmodule

bind cmd_frame_reader cmd_link_props i_props (
    .clk    (clk),
    .rst    (rst),
    .fs     (fs),
    .fd     (fd),
    .status (status)
);

/* bench/cmd_link_tb.sv */
`timescale 1ns/1ps
`include "cmd_link_consts.svh"

module cmd_link_tb;

    localparam int LIMIT = 200;   // Cycles, a frame round trip takes about 40
    localparam int RANDOM_FRAMES = 8;

    logic                        clk;
    logic                        rst;
    cmd_frame_pkg::cmd_req_t     req;
    logic                        send;
    logic                        busy;
    logic                        done;
    cmd_decode_pkg::cmd_status_e status;
    cmd_decode_pkg::cmd_decode_t cmd;

    logic [31:0]                 lfsr_state;
    cmd_decode_pkg::cmd_decode_t last_cmd;   // Model of the last accepted command
    int                          errors;
    int                          tests_run;
    int                          tests_passed;
    bit                          timed_out;

    cmd_link_top i_cmd_link_top (
        .clk    (clk),
        .rst    (rst),
        .req    (req),
        .send   (send),
        .busy   (busy),
        .done   (done),
        .status (status),
        .cmd    (cmd)
    );

    always #2 clk = ~clk;

    // Taps 32, 22, 2 and 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_bits(input int n, output logic [31:0] val);
        val = '0;
        for (int i = 0; i < n; i++) begin
            val = {val[30:0], lfsr_state[31]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic random_valid_req(output cmd_frame_pkg::cmd_req_t r);
        logic [31:0] v;
        r.key = `CMD_KEY;
        draw_bits(2, v);
        r.func = 8'(v % 3) + 8'd1;   // One of the three listed opcodes
        draw_bits(32, v);
        {r.rate, r.lfilt, r.hfilt, r.trig0} = v;
        draw_bits(8, v);
        r.trig1 = v[7:0];
        draw_bits(32, v);
        {r.dly0, r.dly1} = v;
    endtask

    // Key first, then opcode; the checksum always matches what the writer sent
    function automatic cmd_decode_pkg::cmd_status_e expect_status(
        input cmd_frame_pkg::cmd_req_t r);
        if (r.key != `CMD_KEY) return cmd_decode_pkg::ST_BAD_KEY;
        if (r.func < 8'd1 || r.func > 8'd3) return cmd_decode_pkg::ST_BAD_FUNC;
        return cmd_decode_pkg::ST_OK;
    endfunction

    function automatic cmd_decode_pkg::cmd_decode_t fields_of(input cmd_frame_pkg::cmd_req_t r);
        return '{func: cmd_frame_pkg::cmd_func_e'(r.func[3:0]), rate: r.rate,
                 lfilt: r.lfilt, hfilt: r.hfilt, trig0: r.trig0, trig1: r.trig1,
                 dly0: r.dly0, dly1: r.dly1};
    endfunction

    task automatic check_val(input string test, input string what,
                             input logic [95:0] exp, input logic [95:0] act);
        assert (act === exp) else begin
            $display("[ERROR] %s: %s expected %0h, actual %0h", test, what, exp, act);
            errors++;
        end
    endtask

    task automatic wait_idle(input string test);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (busy && n < LIMIT);
        if (busy) begin
            $display("%s: DUT still busy after %0d cycles", test, LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic wait_done(input string test);
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
        end while (!done && n < LIMIT);
        if (!done) begin
            $display("%s: no done pulse within %0d cycles", test, LIMIT);
            timed_out = 1'b1;
        end
    endtask

    task automatic send_req(input cmd_frame_pkg::cmd_req_t r);
        @(posedge clk);
        req  <= r;
        send <= 1'b1;
        @(posedge clk);
        send <= 1'b0;
    endtask

    task automatic run_frame(input string test, input cmd_frame_pkg::cmd_req_t r);
        cmd_decode_pkg::cmd_status_e exp_st;
        wait_idle(test);
        if (timed_out) return;
        send_req(r);
        wait_done(test);
        if (timed_out) return;
        exp_st = expect_status(r);
        if (exp_st == cmd_decode_pkg::ST_OK) last_cmd = fields_of(r);
        check_val(test, "status", 96'(exp_st), 96'(status));
        check_val(test, "cmd", 96'(last_cmd), 96'(cmd));
    endtask

    task automatic report_test(input string test, input int errs_before);
        tests_run++;
        if (errors == errs_before && !timed_out) begin
            tests_passed++;
            $display("%-16s ok", test);
        end else begin
            $display("%-16s %0d wrong value(s)", test, errors - errs_before);
        end
    endtask

    task automatic test_reset();
        int e0;
        e0 = errors;
        @(negedge clk);
        check_val("reset", "busy", 96'(1'b0), 96'(busy));
        check_val("reset", "done", 96'(1'b0), 96'(done));
        check_val("reset", "status", 96'(cmd_decode_pkg::ST_NONE), 96'(status));
        check_val("reset", "cmd", 96'(0), 96'(cmd));
        report_test("reset", e0);
    endtask

    task automatic test_valid_frame();
        int e0;
        cmd_frame_pkg::cmd_req_t r;
        e0 = errors;
        r = '{key: `CMD_KEY, func: 8'd2, rate: 8'd3, lfilt: 8'd8, hfilt: 8'd9,
              trig0: 8'd5, trig1: 8'd6, dly0: 16'h1234, dly1: 16'h5678};
        run_frame("valid_frame", r);
        report_test("valid_frame", e0);
    endtask

    task automatic test_random_frames();
        int e0;
        cmd_frame_pkg::cmd_req_t r;
        e0 = errors;
        for (int i = 0; i < RANDOM_FRAMES && !timed_out; i++) begin
            random_valid_req(r);
            run_frame("random_frames", r);
        end
        report_test("random_frames", e0);
    endtask

    task automatic test_rejected();
        int e0;
        cmd_frame_pkg::cmd_req_t r;
        e0 = errors;
        random_valid_req(r);
        r.key = 16'hA55A;   // Wrong key with a valid opcode
        run_frame("rejected", r);
        r.key  = `CMD_KEY;
        r.func = 8'd0;
        if (!timed_out) run_frame("rejected", r);
        r.func = 8'd9;
        if (!timed_out) run_frame("rejected", r);
        report_test("rejected", e0);
    endtask

    task automatic test_send_while_busy();
        int e0;
        int extra;
        cmd_frame_pkg::cmd_req_t a;
        cmd_frame_pkg::cmd_req_t b;
        e0 = errors;
        extra = 0;
        random_valid_req(a);
        random_valid_req(b);
        b.dly0 = ~a.dly0;   // Makes the two commands tell apart
        wait_idle("send_while_busy");
        if (!timed_out) begin
            send_req(a);
            @(negedge clk);
            check_val("send_while_busy", "busy", 96'(1'b1), 96'(busy));
            send_req(b);
            wait_done("send_while_busy");
        end
        if (!timed_out) begin
            last_cmd = fields_of(a);
            check_val("send_while_busy", "status", 96'(cmd_decode_pkg::ST_OK), 96'(status));
            check_val("send_while_busy", "cmd", 96'(last_cmd), 96'(cmd));
            repeat (60) begin
                @(negedge clk);
                if (done) extra++;
            end
            assert (extra == 0) else begin
                $display("send_while_busy: %0d extra done pulse(s) after the first", extra);
                errors++;
            end
            check_val("send_while_busy", "cmd", 96'(last_cmd), 96'(cmd));
        end
        report_test("send_while_busy", e0);
    endtask

    initial begin
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        send = 1'b0;
        lfsr_state = 32'h5d62;
        last_cmd = '0;
        errors = 0;
        tests_run = 0;
        tests_passed = 0;
        timed_out = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        test_reset();
        if (!timed_out) test_valid_frame();
        if (!timed_out) test_random_frames();
        if (!timed_out) test_rejected();
        if (!timed_out) test_send_while_busy();
        $display("Tests run %0d, passed %0d, wrong values %0d", tests_run, tests_passed, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test completed successfully");
        end else begin
            if (timed_out) $display("Run stopped early on a timeout");
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* src.f */
+incdir+source
source/cmd_frame_pkg.sv
source/cmd_decode_pkg.sv
source/cmd_frame_writer.sv
source/cmd_frame_ram.sv
source/cmd_frame_reader.sv
source/cmd_link_top.sv
bench/cmd_link_props.sv
bench/cmd_link_tb.sv

/* Makefile */
VERILATOR ?= verilator
TOP       ?= cmd_link_tb
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only --timing --assert

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then \
		echo "Simulation FAILED, see $(LOG)"; exit 1; \
	elif ! grep -q "Test completed successfully" $(LOG); then \
		echo "Simulation ended without a result, see $(LOG)"; exit 1; \
	else \
		echo "Simulation passed"; \
	fi

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
